//--- hw/radio_consts.svh
/*
 * global sizing for the radio front-end fabric
 * channel count, sample and settings widths
 * depth of the time-sync synchronizer
 */

`ifndef RADIO_CONSTS_SVH
`define RADIO_CONSTS_SVH

//////////////////////////////
// channel layout
//////////////////////////////

// two daughterboards, two rx channels each
`define RADIO_NUM_CHAN 4

//////////////////////////////
// bus widths
//////////////////////////////

`define RADIO_SAMP_W 32 // one adc word, i in upper half, q in lower
`define RADIO_ADDR_W 8  // settings and readback address

//////////////////////////////
// time sync
//////////////////////////////

`define RADIO_SYNC_STAGES 2 // flops between i_time_sync and the cores

`endif

//--- hw/radio_types_pkg.sv
/*
 * sample and channel types
 * channel index, i/q pair and the raw-or-i/q sample word
 */

package radio_types_pkg;

   `include "radio_consts.svh"

   // selects one of the four front-end cores
   typedef logic [$clog2(`RADIO_NUM_CHAN)-1:0] chan_idx_t;

   //////////////////////////////
   // sample word views
   //////////////////////////////

   // i sits in the upper half, same as the adc word
   typedef struct packed {
      logic signed [`RADIO_SAMP_W/2-1:0] i;
      logic signed [`RADIO_SAMP_W/2-1:0] q;
   } iq_pair_t;

   // one 32 bit word seen either as i/q or as plain bits
   // rx samples and dc offset are used as i/q, settings data lands raw
   typedef union packed {
      iq_pair_t                 iq;
      logic [`RADIO_SAMP_W-1:0] raw;
   } radio_word_u;

endpackage

//--- hw/fe_regs_pkg.sv
/*
 * front-end register map
 * address enumeration and the value returned for unmapped reads
 */

package fe_regs_pkg;

   `include "radio_consts.svh"

   //////////////////////////////
   // register addresses
   //////////////////////////////

   typedef enum logic [`RADIO_ADDR_W-1:0] {
      // writable, each reads back its own value
      REG_DC_OFFSET = 8'h00, // i/q offset subtracted from rx
      REG_GPIO_OUT  = 8'h01, // db gpio output value
      REG_GPIO_DDR  = 8'h02, // db gpio direction, 1 = drive
      REG_LEDS      = 8'h03, // 3 bit led overlay
      REG_MISC_OUT  = 8'h04, // misc word to the board
      // readback only
      REG_GPIO_IN   = 8'h10, // db gpio pins
      REG_RX_COUNT  = 8'h11, // samples since reset or time sync
      REG_MISC_IN   = 8'h12  // misc word from the board
   } fe_reg_e;

   // anything not in the map reads as this
   localparam logic [`RADIO_SAMP_W-1:0] FE_RB_DEFAULT = '0;

endpackage

//--- hw/fe_ctrl_if.sv
/*
 * per-channel front-end control interface
 * strobed settings writes and strobed readback
 * router and core modports
 */

`timescale 1ns/10ps

`include "radio_consts.svh"

interface fe_ctrl_if;

   //////////////////////////////
   // settings write
   //////////////////////////////

   logic                     set_stb;  // one cycle per write
   logic [`RADIO_ADDR_W-1:0] set_addr;
   logic [`RADIO_SAMP_W-1:0] set_data;

   //////////////////////////////
   // readback
   //////////////////////////////

   logic                     rb_stb;   // one cycle per read
   logic [`RADIO_ADDR_W-1:0] rb_addr;
   logic [`RADIO_SAMP_W-1:0] rb_data;  // registered by the core, cycle after rb_stb

   // router side issues requests, collects rb_data
   modport router (
      output set_stb, set_addr, set_data,
      output rb_stb, rb_addr,
      input  rb_data
   );

   // core side
   modport core (
      input  set_stb, set_addr, set_data,
      input  rb_stb, rb_addr,
      output rb_data
   );

endinterface

//--- hw/fe_ctrl_router.sv
/*
 * settings and readback router for the four front-end cores
 * write strobe steered to one channel, readback request registered
 * two-deep channel pipeline picks the answering core
 */

`timescale 1ns/10ps

`include "radio_consts.svh"

module fe_ctrl_router import radio_types_pkg::*; (
   input  logic                     i_clk,
   input  logic                     i_rst,
   // settings write
   input  logic                     i_set_stb,
   input  chan_idx_t                i_set_chan,
   input  logic [`RADIO_ADDR_W-1:0] i_set_addr,
   input  logic [`RADIO_SAMP_W-1:0] i_set_data,
   // readback request and answer
   input  logic                     i_rb_stb,
   input  chan_idx_t                i_rb_chan,
   input  logic [`RADIO_ADDR_W-1:0] i_rb_addr,
   output logic                     o_rb_valid,
   output logic [`RADIO_SAMP_W-1:0] o_rb_data,
   // towards the cores
   fe_ctrl_if.router                fe_ctrl [`RADIO_NUM_CHAN]
);

   logic [1:0]               rb_vld_d;          // [0] at the core, [1] data ready
   chan_idx_t                rb_chan_d [2];     // requester, in step with rb_vld_d
   logic [`RADIO_ADDR_W-1:0] rb_addr_q;
   logic [`RADIO_SAMP_W-1:0] rb_data_w [`RADIO_NUM_CHAN];

   //////////////////////////////
   // request pipeline
   //////////////////////////////

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rb_vld_d   <= '0;
         o_rb_valid <= 1'b0;
      end else begin
         rb_vld_d   <= {rb_vld_d[0], i_rb_stb};
         o_rb_valid <= rb_vld_d[1];
      end
   end

   // requester channel and address travel beside rb_vld_d
   always_ff @(posedge i_clk) begin
      rb_chan_d[0] <= i_rb_chan;
      rb_chan_d[1] <= rb_chan_d[0];
      rb_addr_q    <= i_rb_addr;
   end

   //////////////////////////////
   // per channel fan out
   //////////////////////////////

   for (genvar g = 0; g < `RADIO_NUM_CHAN; g++) begin : gen_chan
      // writes go straight through and only the selected strobe fires
      assign fe_ctrl[g].set_stb  = i_set_stb && (i_set_chan == chan_idx_t'(g));
      assign fe_ctrl[g].set_addr = i_set_addr;
      assign fe_ctrl[g].set_data = i_set_data;
      // readback one cycle behind the request
      assign fe_ctrl[g].rb_stb   = rb_vld_d[0] && (rb_chan_d[0] == chan_idx_t'(g));
      assign fe_ctrl[g].rb_addr  = rb_addr_q;
      assign rb_data_w[g]        = fe_ctrl[g].rb_data;
   end

   // pick the core that answered last cycle by the delayed channel
   always_ff @(posedge i_clk) begin
      o_rb_data <= rb_data_w[rb_chan_d[1]];
   end

endmodule

//--- hw/db_fe_core.sv
/*
 * per-channel front-end core
 * settings registers and readback mux
 * rx dc-offset correction on i and q, rx sample counter
 */

`timescale 1ns/10ps

`include "radio_consts.svh"

module db_fe_core import radio_types_pkg::*; import fe_regs_pkg::*; (
   input  logic                     i_clk,
   input  logic                     i_rst,
   fe_ctrl_if.core                  fe_ctrl,
   input  logic                     i_time_sync,   // already in radio_clk
   // rx sample path
   input  logic                     i_rx_stb,
   input  radio_word_u              i_rx_data,
   output logic                     o_rx_stb,
   output radio_word_u              o_rx_data,
   // daughterboard io
   input  logic [`RADIO_SAMP_W-1:0] i_gpio_in,
   output logic [`RADIO_SAMP_W-1:0] o_gpio_out,
   output logic [`RADIO_SAMP_W-1:0] o_gpio_ddr,
   output logic [2:0]               o_leds,
   input  logic [`RADIO_SAMP_W-1:0] i_misc_in,
   output logic [`RADIO_SAMP_W-1:0] o_misc_out
);

   radio_word_u              dc_offset;   // written raw, applied as i/q
   logic [`RADIO_SAMP_W-1:0] gpio_out_q;
   logic [`RADIO_SAMP_W-1:0] gpio_ddr_q;
   logic [2:0]               leds_q;
   logic [`RADIO_SAMP_W-1:0] misc_out_q;
   logic [31:0]              rx_count;

   //////////////////////////////
   // settings registers
   //////////////////////////////

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         dc_offset  <= '0;
         gpio_out_q <= '0;
         gpio_ddr_q <= '0;
         leds_q     <= '0;
         misc_out_q <= '0;
      end else if (fe_ctrl.set_stb) begin
         case (fe_reg_e'(fe_ctrl.set_addr))
            REG_DC_OFFSET: dc_offset.raw <= fe_ctrl.set_data;
            REG_GPIO_OUT:  gpio_out_q    <= fe_ctrl.set_data;
            REG_GPIO_DDR:  gpio_ddr_q    <= fe_ctrl.set_data;
            REG_LEDS:      leds_q        <= fe_ctrl.set_data[2:0]; // upper bits dropped
            REG_MISC_OUT:  misc_out_q    <= fe_ctrl.set_data;
            default: ;                                             // read-only or unmapped
         endcase
      end
   end

   // straight to the pins while the board map adds the misc register
   assign o_gpio_out = gpio_out_q;
   assign o_gpio_ddr = gpio_ddr_q;
   assign o_leds     = leds_q;
   assign o_misc_out = misc_out_q;

   //////////////////////////////
   // rx correction
   //////////////////////////////

   always_ff @(posedge i_clk) begin
      if (i_rst) o_rx_stb <= 1'b0;
      else       o_rx_stb <= i_rx_stb;
   end

   // i and q subtracted on their own and each wraps at 16 bits
   always_ff @(posedge i_clk) begin
      if (i_rx_stb) begin
         o_rx_data.iq.i <= i_rx_data.iq.i - dc_offset.iq.i;
         o_rx_data.iq.q <= i_rx_data.iq.q - dc_offset.iq.q;
      end
   end

   // time sync wins over a same-cycle strobe
   always_ff @(posedge i_clk) begin
      if (i_rst || i_time_sync) rx_count <= '0;
      else if (i_rx_stb)        rx_count <= rx_count + 32'd1;
   end

   //////////////////////////////
   // readback
   //////////////////////////////

   always_ff @(posedge i_clk) begin
      if (fe_ctrl.rb_stb) begin
         case (fe_reg_e'(fe_ctrl.rb_addr))
            REG_DC_OFFSET: fe_ctrl.rb_data <= dc_offset.raw;
            REG_GPIO_OUT:  fe_ctrl.rb_data <= gpio_out_q;
            REG_GPIO_DDR:  fe_ctrl.rb_data <= gpio_ddr_q;
            REG_LEDS:      fe_ctrl.rb_data <= {{(`RADIO_SAMP_W-3){1'b0}}, leds_q};
            REG_MISC_OUT:  fe_ctrl.rb_data <= misc_out_q;
            REG_GPIO_IN:   fe_ctrl.rb_data <= i_gpio_in;  // zero on odd channels
            REG_RX_COUNT:  fe_ctrl.rb_data <= rx_count;
            REG_MISC_IN:   fe_ctrl.rb_data <= i_misc_in;
            default:       fe_ctrl.rb_data <= FE_RB_DEFAULT;
         endcase
      end
   end

endmodule

//--- hw/radio_board_map.sv
/*
 * board to channel mapping for two daughterboards
 * adc fan out, gpio and misc steering, led overlay
 * time-sync synchronizer
 */

`timescale 1ns/10ps

`include "radio_consts.svh"

module radio_board_map import radio_types_pkg::*; (
   input  logic                     i_clk,
   input  logic                     i_rst,
   // board side
   input  logic [`RADIO_SAMP_W-1:0] i_rx0,
   input  logic [`RADIO_SAMP_W-1:0] i_rx1,
   input  logic                     i_rx0_stb,
   input  logic                     i_rx1_stb,
   input  logic [`RADIO_SAMP_W-1:0] i_db0_gpio_in,
   input  logic [`RADIO_SAMP_W-1:0] i_db1_gpio_in,
   output logic [`RADIO_SAMP_W-1:0] o_db0_gpio_out,
   output logic [`RADIO_SAMP_W-1:0] o_db1_gpio_out,
   output logic [`RADIO_SAMP_W-1:0] o_db0_gpio_ddr,
   output logic [`RADIO_SAMP_W-1:0] o_db1_gpio_ddr,
   output logic [2:0]               o_radio_led0,
   output logic [2:0]               o_radio_led1,
   input  logic [`RADIO_SAMP_W-1:0] i_radio0_misc_in,
   input  logic [`RADIO_SAMP_W-1:0] i_radio1_misc_in,
   output logic [`RADIO_SAMP_W-1:0] o_radio0_misc_out,
   output logic [`RADIO_SAMP_W-1:0] o_radio1_misc_out,
   input  logic                     i_time_sync,     // async
   // core side, one entry per channel
   output logic                     o_rx_stb   [`RADIO_NUM_CHAN],
   output radio_word_u              o_rx_data  [`RADIO_NUM_CHAN],
   output logic [`RADIO_SAMP_W-1:0] o_gpio_in  [`RADIO_NUM_CHAN],
   input  logic [`RADIO_SAMP_W-1:0] i_gpio_out [`RADIO_NUM_CHAN],
   input  logic [`RADIO_SAMP_W-1:0] i_gpio_ddr [`RADIO_NUM_CHAN],
   input  logic [2:0]               i_leds     [`RADIO_NUM_CHAN],
   output logic [`RADIO_SAMP_W-1:0] o_misc_in  [`RADIO_NUM_CHAN],
   input  logic [`RADIO_SAMP_W-1:0] i_misc_out [`RADIO_NUM_CHAN],
   output logic                     o_time_sync
);

   logic [`RADIO_SYNC_STAGES-1:0] sync_q;

   //////////////////////////////
   // adc and gpio
   //////////////////////////////

   // each adc word feeds both channels of its board
   assign o_rx_data[0] = i_rx0;
   assign o_rx_stb[0]  = i_rx0_stb;
   assign o_rx_data[1] = i_rx0;
   assign o_rx_stb[1]  = i_rx0_stb;
   assign o_rx_data[2] = i_rx1;
   assign o_rx_stb[2]  = i_rx1_stb;
   assign o_rx_data[3] = i_rx1;
   assign o_rx_stb[3]  = i_rx1_stb;

   // only even channels own the board pins
   assign o_gpio_in[0]   = i_db0_gpio_in;
   assign o_gpio_in[1]   = '0;
   assign o_gpio_in[2]   = i_db1_gpio_in;
   assign o_gpio_in[3]   = '0;
   assign o_db0_gpio_out = i_gpio_out[0];   // [1] unused
   assign o_db1_gpio_out = i_gpio_out[2];   // [3] unused
   assign o_db0_gpio_ddr = i_gpio_ddr[0];
   assign o_db1_gpio_ddr = i_gpio_ddr[2];

   // both channels of a board light the same leds
   assign o_radio_led0 = i_leds[0] | i_leds[1];
   assign o_radio_led1 = i_leds[2] | i_leds[3];

   //////////////////////////////
   // misc words and time sync
   //////////////////////////////

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_radio0_misc_out <= '0;
         o_radio1_misc_out <= '0;
         o_misc_in[0]      <= '0;
         o_misc_in[2]      <= '0;
         sync_q            <= '0;
      end else begin
         o_radio0_misc_out <= i_misc_out[0];
         o_radio1_misc_out <= i_misc_out[2];
         o_misc_in[0]      <= i_radio0_misc_in;
         o_misc_in[2]      <= i_radio1_misc_in;
         sync_q            <= {sync_q[`RADIO_SYNC_STAGES-2:0], i_time_sync};
      end
   end

   assign o_misc_in[1] = '0;   // odd channels see no board
   assign o_misc_in[3] = '0;
   assign o_time_sync  = sync_q[`RADIO_SYNC_STAGES-1];

endmodule

//--- hw/radio_core_top.sv
/*
 * radio front-end fabric top level
 * control router, board map, four front-end cores
 */

`timescale 1ns/10ps

`include "radio_consts.svh"

module radio_core_top import radio_types_pkg::*; (
   input  logic                     radio_clk,
   input  logic                     i_rst,
   // settings and readback
   input  logic                     i_set_stb,
   input  logic [1:0]               i_set_chan,
   input  logic [`RADIO_ADDR_W-1:0] i_set_addr,
   input  logic [`RADIO_SAMP_W-1:0] i_set_data,
   input  logic                     i_rb_stb,
   input  logic [1:0]               i_rb_chan,
   input  logic [`RADIO_ADDR_W-1:0] i_rb_addr,
   output logic                     o_rb_valid,
   output logic [`RADIO_SAMP_W-1:0] o_rb_data,
   // board 0
   input  logic [`RADIO_SAMP_W-1:0] i_rx0,
   input  logic                     i_rx0_stb,
   input  logic [`RADIO_SAMP_W-1:0] i_db0_gpio_in,
   output logic [`RADIO_SAMP_W-1:0] o_db0_gpio_out,
   output logic [`RADIO_SAMP_W-1:0] o_db0_gpio_ddr,
   output logic [2:0]               o_radio_led0,
   input  logic [`RADIO_SAMP_W-1:0] i_radio0_misc_in,
   output logic [`RADIO_SAMP_W-1:0] o_radio0_misc_out,
   // board 1
   input  logic [`RADIO_SAMP_W-1:0] i_rx1,
   input  logic                     i_rx1_stb,
   input  logic [`RADIO_SAMP_W-1:0] i_db1_gpio_in,
   output logic [`RADIO_SAMP_W-1:0] o_db1_gpio_out,
   output logic [`RADIO_SAMP_W-1:0] o_db1_gpio_ddr,
   output logic [2:0]               o_radio_led1,
   input  logic [`RADIO_SAMP_W-1:0] i_radio1_misc_in,
   output logic [`RADIO_SAMP_W-1:0] o_radio1_misc_out,
   input  logic                     i_time_sync,
   // corrected rx per channel
   output logic [`RADIO_NUM_CHAN-1:0] o_rx_stb,
   output logic [`RADIO_SAMP_W-1:0]   o_rx_data [`RADIO_NUM_CHAN]
);

   fe_ctrl_if fe_ctrl [`RADIO_NUM_CHAN] ();

   logic                     rx_stb   [`RADIO_NUM_CHAN];   // board map to cores
   radio_word_u              rx_data  [`RADIO_NUM_CHAN];
   logic [`RADIO_SAMP_W-1:0] gpio_in  [`RADIO_NUM_CHAN];
   logic [`RADIO_SAMP_W-1:0] gpio_out [`RADIO_NUM_CHAN];
   logic [`RADIO_SAMP_W-1:0] gpio_ddr [`RADIO_NUM_CHAN];
   logic [2:0]               leds     [`RADIO_NUM_CHAN];
   logic [`RADIO_SAMP_W-1:0] misc_in  [`RADIO_NUM_CHAN];
   logic [`RADIO_SAMP_W-1:0] misc_out [`RADIO_NUM_CHAN];
   logic                     time_sync_r;                  // synchronized

   fe_ctrl_router u_router (
      .i_clk(radio_clk), .i_rst(i_rst),
      .i_set_stb(i_set_stb), .i_set_chan(i_set_chan),
      .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .i_rb_stb(i_rb_stb), .i_rb_chan(i_rb_chan), .i_rb_addr(i_rb_addr),
      .o_rb_valid(o_rb_valid), .o_rb_data(o_rb_data),
      .fe_ctrl(fe_ctrl)
   );

   radio_board_map u_board_map (
      .i_clk(radio_clk), .i_rst(i_rst),
      .i_rx0(i_rx0), .i_rx1(i_rx1), .i_rx0_stb(i_rx0_stb), .i_rx1_stb(i_rx1_stb),
      .i_db0_gpio_in(i_db0_gpio_in), .i_db1_gpio_in(i_db1_gpio_in),
      .o_db0_gpio_out(o_db0_gpio_out), .o_db1_gpio_out(o_db1_gpio_out),
      .o_db0_gpio_ddr(o_db0_gpio_ddr), .o_db1_gpio_ddr(o_db1_gpio_ddr),
      .o_radio_led0(o_radio_led0), .o_radio_led1(o_radio_led1),
      .i_radio0_misc_in(i_radio0_misc_in), .i_radio1_misc_in(i_radio1_misc_in),
      .o_radio0_misc_out(o_radio0_misc_out), .o_radio1_misc_out(o_radio1_misc_out),
      .i_time_sync(i_time_sync),
      .o_rx_stb(rx_stb), .o_rx_data(rx_data), .o_gpio_in(gpio_in),
      .i_gpio_out(gpio_out), .i_gpio_ddr(gpio_ddr), .i_leds(leds),
      .o_misc_in(misc_in), .i_misc_out(misc_out), .o_time_sync(time_sync_r)
   );

   for (genvar g = 0; g < `RADIO_NUM_CHAN; g++) begin : gen_chan
      db_fe_core u_fe_core (
         .i_clk(radio_clk), .i_rst(i_rst), .fe_ctrl(fe_ctrl[g]), .i_time_sync(time_sync_r),
         .i_rx_stb(rx_stb[g]), .i_rx_data(rx_data[g]),
         .o_rx_stb(o_rx_stb[g]), .o_rx_data(o_rx_data[g]),
         .i_gpio_in(gpio_in[g]), .o_gpio_out(gpio_out[g]), .o_gpio_ddr(gpio_ddr[g]),
         .o_leds(leds[g]), .i_misc_in(misc_in[g]), .o_misc_out(misc_out[g])
      );
   end

endmodule

//--- bench/radio_core_asserts.sv
/*
 * concurrent timing checks on the radio top level
 * readback latency, rx strobe latency, quiet outputs in reset
 * bound into radio_core_top
 */

`timescale 1ns/10ps

module radio_core_asserts (
   input  logic       i_clk,
   input  logic       i_rst,
   input  logic       i_rb_stb,
   input  logic       i_rb_valid,
   input  logic       i_rx0_stb,
   input  logic       i_rx1_stb,
   input  logic [3:0] i_rx_stb
);

   // valid is set on the second edge after the request edge
   // so the sampled value trails the sampled request by three
   a_rb_valid : assert property (@(posedge i_clk) disable iff (i_rst)
      i_rb_valid == $past(i_rb_stb, 3))
      else $error("readback valid out of step with its request");

   // each board strobe shows on both of its channels one edge later
   a_rx_stb : assert property (@(posedge i_clk) disable iff (i_rst)
      i_rx_stb == $past({i_rx1_stb, i_rx1_stb, i_rx0_stb, i_rx0_stb}))
      else $error("rx strobe does not follow the board strobe");

   // outputs settle on the first reset edge
   a_rst_quiet : assert property (@(posedge i_clk)
      (i_rst && $past(i_rst)) |-> (!i_rb_valid && i_rx_stb == 4'b0000))
      else $error("output strobe high during reset");

endmodule

bind radio_core_top radio_core_asserts u_asserts (
   .i_clk(radio_clk), .i_rst(i_rst),
   .i_rb_stb(i_rb_stb), .i_rb_valid(o_rb_valid),
   .i_rx0_stb(i_rx0_stb), .i_rx1_stb(i_rx1_stb), .i_rx_stb(o_rx_stb)
);

//--- bench/radio_core_tb.sv
/*
 * testbench for the radio front-end fabric
 * clock, reset, step table applied in a loop
 * register shadow model, pin checks, watchdog
 */

`timescale 1ns/10ps

`include "radio_consts.svh"

module radio_core_tb import fe_regs_pkg::*;;

   localparam int OP_WR = 0, OP_RD = 1, OP_RD2 = 2, OP_SMP = 3, OP_SYNC = 4, OP_IN = 5;
   localparam int RB_WAIT = 8; // cycles before a missing answer counts as lost
   localparam int RX_WAIT = 4;
   localparam logic [`RADIO_ADDR_W-1:0] WR_ADDR [5] =
      '{REG_DC_OFFSET, REG_GPIO_OUT, REG_GPIO_DDR, REG_LEDS, REG_MISC_OUT};
   localparam logic [31:0] LED_VAL [4] = '{32'h1, 32'h4, 32'h2, 32'h1};

   typedef struct {
      int          op;
      logic [1:0]  chan;  // channel, or board for samples and inputs
      logic [7:0]  addr;
      logic [31:0] data;  // write data, sample count, second read's expected
      logic [31:0] exp;
   } step_t;

   logic        radio_clk = 1'b0;
   logic        i_rst, i_set_stb, i_rb_stb, i_rx0_stb, i_rx1_stb, i_time_sync;
   logic [1:0]  i_set_chan, i_rb_chan;
   logic [7:0]  i_set_addr, i_rb_addr;
   logic [31:0] i_set_data, i_rx0, i_rx1, i_db0_gpio_in, i_db1_gpio_in;
   logic [31:0] i_radio0_misc_in, i_radio1_misc_in;
   logic        o_rb_valid;
   logic [31:0] o_rb_data, o_db0_gpio_out, o_db1_gpio_out, o_db0_gpio_ddr, o_db1_gpio_ddr;
   logic [31:0] o_radio0_misc_out, o_radio1_misc_out;
   logic [2:0]  o_radio_led0, o_radio_led1;
   logic [3:0]  o_rx_stb;
   logic [31:0] o_rx_data [4];

   step_t       steps [$];
   bit          table_ready = 1'b0;
   int          errors = 0, checks = 0, test_err, cur_test;
   // shadow of each core's writable registers
   logic [31:0] m_dc [4], m_gpio [4], m_ddr [4], m_misc [4];
   logic [2:0]  m_leds [4];

   always #4 radio_clk = ~radio_clk; // 8 ns

   radio_core_top i_dut (
      .radio_clk(radio_clk), .i_rst(i_rst),
      .i_set_stb(i_set_stb), .i_set_chan(i_set_chan),
      .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .i_rb_stb(i_rb_stb), .i_rb_chan(i_rb_chan), .i_rb_addr(i_rb_addr),
      .o_rb_valid(o_rb_valid), .o_rb_data(o_rb_data),
      .i_rx0(i_rx0), .i_rx0_stb(i_rx0_stb), .i_db0_gpio_in(i_db0_gpio_in),
      .o_db0_gpio_out(o_db0_gpio_out), .o_db0_gpio_ddr(o_db0_gpio_ddr),
      .o_radio_led0(o_radio_led0), .i_radio0_misc_in(i_radio0_misc_in),
      .o_radio0_misc_out(o_radio0_misc_out),
      .i_rx1(i_rx1), .i_rx1_stb(i_rx1_stb), .i_db1_gpio_in(i_db1_gpio_in),
      .o_db1_gpio_out(o_db1_gpio_out), .o_db1_gpio_ddr(o_db1_gpio_ddr),
      .o_radio_led1(o_radio_led1), .i_radio1_misc_in(i_radio1_misc_in),
      .o_radio1_misc_out(o_radio1_misc_out),
      .i_time_sync(i_time_sync), .o_rx_stb(o_rx_stb), .o_rx_data(o_rx_data)
   );

   //////////////////////////////
   // step table
   //////////////////////////////

   function automatic void add_step(input int op, input logic [1:0] chan,
                                    input logic [7:0] addr, input logic [31:0] data,
                                    input logic [31:0] exp);
      step_t s;
      s.op   = op;
      s.chan = chan;
      s.addr = addr;
      s.data = data;
      s.exp  = exp;
      steps.push_back(s);
   endfunction

   // distinct value per channel and register
   function automatic logic [31:0] wr_value(input int c, input int k);
      case (k)
         0:       return 32'h0120_FFF0 + c * 32'h0005_0003; // q offset negative
         1:       return 32'h6000_0000 + c * 32'h0000_0111;
         2:       return 32'h0F0F_0000 | c;
         3:       return 32'hA5A5_A5A0 | LED_VAL[c];        // only [2:0] kept
         default: return 32'hC0DE_0000 + c;
      endcase
   endfunction

   function automatic string op_name(input int op);
      case (op)
         OP_WR:   return "write";
         OP_RD:   return "read";
         OP_RD2:  return "read2";
         OP_SMP:  return "sample";
         OP_SYNC: return "sync";
         default: return "inputs";
      endcase
   endfunction

   task automatic build_table();
      logic [31:0] v;
      for (int c = 0; c < 4; c++) begin // everything zero out of reset
         for (int k = 0; k < 5; k++) add_step(OP_RD, 2'(c), WR_ADDR[k], 32'h0, 32'h0);
         add_step(OP_RD, 2'(c), REG_RX_COUNT, 32'h0, 32'h0);
      end
      add_step(OP_RD, 2'd0, 8'h55, 32'h0, 32'h0); // unmapped
      add_step(OP_RD, 2'd3, 8'h05, 32'h0, 32'h0);
      for (int c = 0; c < 4; c++) begin
         for (int k = 0; k < 5; k++) begin
            v = wr_value(c, k);
            add_step(OP_WR, 2'(c), WR_ADDR[k], v, 32'h0);
            add_step(OP_RD, 2'(c), WR_ADDR[k], 32'h0, (k == 3) ? (v & 32'h7) : v);
         end
      end
      add_step(OP_RD2, 2'd0, REG_GPIO_OUT, wr_value(1, 1), wr_value(0, 1));
      add_step(OP_RD2, 2'd2, REG_MISC_OUT, wr_value(3, 4), wr_value(2, 4));
      add_step(OP_SMP, 2'd0, 8'h0, 32'd6, 32'h0);
      add_step(OP_SMP, 2'd1, 8'h0, 32'd6, 32'h0);
      for (int c = 0; c < 4; c++) add_step(OP_RD, 2'(c), REG_RX_COUNT, 32'h0, 32'd6);
      add_step(OP_SYNC, 2'd0, 8'h0, 32'h0, 32'h0);
      for (int c = 0; c < 4; c++) add_step(OP_RD, 2'(c), REG_RX_COUNT, 32'h0, 32'd0);
      add_step(OP_SMP, 2'd0, 8'h0, 32'd3, 32'h0); // counting again after sync
      add_step(OP_RD, 2'd0, REG_RX_COUNT, 32'h0, 32'd3);
      add_step(OP_RD, 2'd1, REG_RX_COUNT, 32'h0, 32'd3);
      add_step(OP_RD, 2'd2, REG_RX_COUNT, 32'h0, 32'd0);
      add_step(OP_IN, 2'd0, 8'h0, 32'h1357_9BDF, 32'h0);
      add_step(OP_RD, 2'd0, REG_GPIO_IN, 32'h0, 32'h1357_9BDF);
      add_step(OP_RD, 2'd1, REG_GPIO_IN, 32'h0, 32'h0);
      add_step(OP_RD, 2'd0, REG_MISC_IN, 32'h0, ~32'h1357_9BDF);
      add_step(OP_RD, 2'd1, REG_MISC_IN, 32'h0, 32'h0);
      add_step(OP_IN, 2'd1, 8'h0, 32'h2468_ACE0, 32'h0);
      add_step(OP_RD, 2'd2, REG_GPIO_IN, 32'h0, 32'h2468_ACE0);
      add_step(OP_RD, 2'd3, REG_GPIO_IN, 32'h0, 32'h0);
      add_step(OP_RD, 2'd2, REG_MISC_IN, 32'h0, ~32'h2468_ACE0);
      add_step(OP_RD, 2'd3, REG_MISC_IN, 32'h0, 32'h0);
   endtask

   //////////////////////////////
   // checks and operations
   //////////////////////////////

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("FAILED %s: got %h expected %h", name, got, exp);
         errors++;
         test_err++;
      end
   endtask

   // only the even channels reach the pins and leds are or'ed per board
   task automatic check_pins();
      check_val("o_db0_gpio_out", o_db0_gpio_out, m_gpio[0]);
      check_val("o_db1_gpio_out", o_db1_gpio_out, m_gpio[2]);
      check_val("o_db0_gpio_ddr", o_db0_gpio_ddr, m_ddr[0]);
      check_val("o_db1_gpio_ddr", o_db1_gpio_ddr, m_ddr[2]);
      check_val("o_radio_led0", 32'(o_radio_led0), 32'(m_leds[0] | m_leds[1]));
      check_val("o_radio_led1", 32'(o_radio_led1), 32'(m_leds[2] | m_leds[3]));
   endtask

   task automatic check_misc_pins();
      check_val("o_radio0_misc_out", o_radio0_misc_out, m_misc[0]);
      check_val("o_radio1_misc_out", o_radio1_misc_out, m_misc[2]);
   endtask

   task automatic do_write(input logic [1:0] c, input logic [7:0] a, input logic [31:0] d);
      @(posedge radio_clk);
      i_set_stb  <= 1'b1;
      i_set_chan <= c;
      i_set_addr <= a;
      i_set_data <= d;
      @(posedge radio_clk);
      i_set_stb  <= 1'b0;
      @(negedge radio_clk);
      check_misc_pins(); // misc pin still one cycle behind
      case (a)
         REG_DC_OFFSET: m_dc[c]   = d;
         REG_GPIO_OUT:  m_gpio[c] = d;
         REG_GPIO_DDR:  m_ddr[c]  = d;
         REG_LEDS:      m_leds[c] = d[2:0];
         REG_MISC_OUT:  m_misc[c] = d;
         default: ;
      endcase
      check_pins();
      @(negedge radio_clk);
      check_misc_pins();
   endtask

   task automatic collect_rb(input logic [31:0] exp);
      int n;
      n = 0;
      do begin
         @(negedge radio_clk);
         n++;
      end while (!o_rb_valid && n < RB_WAIT);
      if (!o_rb_valid) begin
         $display("test %0d: no readback answer within %0d cycles", cur_test, RB_WAIT);
         errors++;
         test_err++;
      end else begin
         check_val("o_rb_data", o_rb_data, exp);
      end
   endtask

   task automatic do_read(input logic [1:0] c, input logic [7:0] a, input logic [31:0] exp);
      @(posedge radio_clk);
      i_rb_stb  <= 1'b1;
      i_rb_chan <= c;
      i_rb_addr <= a;
      @(posedge radio_clk);
      i_rb_stb  <= 1'b0;
      collect_rb(exp);
   endtask

   // channel c then c+1 on back to back cycles
   task automatic do_read2(input logic [1:0] c, input logic [7:0] a,
                           input logic [31:0] exp0, input logic [31:0] exp1);
      @(posedge radio_clk);
      i_rb_stb  <= 1'b1;
      i_rb_chan <= c;
      i_rb_addr <= a;
      @(posedge radio_clk);
      i_rb_chan <= c + 2'd1;
      @(posedge radio_clk);
      i_rb_stb  <= 1'b0;
      collect_rb(exp0);
      collect_rb(exp1);
   endtask

   task automatic do_sample(input int b, input int reps);
      logic [31:0] smp;
      logic [15:0] ei, eq;
      int          n;
      for (int k = 0; k < reps; k++) begin
         smp = $urandom;
         @(posedge radio_clk);
         if (b == 1) begin
            i_rx1     <= smp;
            i_rx1_stb <= 1'b1;
         end else begin
            i_rx0     <= smp;
            i_rx0_stb <= 1'b1;
         end
         @(posedge radio_clk);
         i_rx0_stb <= 1'b0;
         i_rx1_stb <= 1'b0;
         n = 0;
         do begin
            @(negedge radio_clk);
            n++;
         end while (!o_rx_stb[2*b] && n < RX_WAIT);
         if (!o_rx_stb[2*b]) begin
            $display("test %0d: no rx strobe from board %0d", cur_test, b);
            errors++;
            test_err++;
         end else begin
            check_val("o_rx_stb", 32'(o_rx_stb), (b == 1) ? 32'hC : 32'h3);
            for (int c = 2 * b; c < 2 * b + 2; c++) begin
               ei = smp[31:16] - m_dc[c][31:16]; // wraps at 16 bits
               eq = smp[15:0] - m_dc[c][15:0];
               check_val($sformatf("o_rx_data[%0d]", c), o_rx_data[c], {ei, eq});
            end
         end
      end
   endtask

   //////////////////////////////
   // main sequence and watchdog
   //////////////////////////////

   initial begin
      i_rst = 1'b1;
      i_set_stb = 1'b0;
      i_set_chan = 2'd0;
      i_set_addr = 8'h0;
      i_set_data = 32'h0;
      i_rb_stb = 1'b0;
      i_rb_chan = 2'd0;
      i_rb_addr = 8'h0;
      i_rx0 = 32'h0;
      i_rx1 = 32'h0;
      i_rx0_stb = 1'b0;
      i_rx1_stb = 1'b0;
      i_db0_gpio_in = 32'h0;
      i_db1_gpio_in = 32'h0;
      i_radio0_misc_in = 32'h0;
      i_radio1_misc_in = 32'h0;
      i_time_sync = 1'b0;
      for (int c = 0; c < 4; c++) begin
         m_dc[c] = 32'h0;
         m_gpio[c] = 32'h0;
         m_ddr[c] = 32'h0;
         m_misc[c] = 32'h0;
         m_leds[c] = 3'h0;
      end
      void'($urandom(28)); // seeds the generator
      build_table();
      table_ready = 1'b1;
      repeat (5) @(posedge radio_clk);
      i_rst <= 1'b0;
      foreach (steps[n]) begin
         test_err = 0;
         cur_test = n;
         case (steps[n].op)
            OP_WR:  do_write(steps[n].chan, steps[n].addr, steps[n].data);
            OP_RD:  do_read(steps[n].chan, steps[n].addr, steps[n].exp);
            OP_RD2: do_read2(steps[n].chan, steps[n].addr, steps[n].exp, steps[n].data);
            OP_SMP: do_sample(int'(steps[n].chan), int'(steps[n].data));
            OP_SYNC: begin
               @(posedge radio_clk);
               i_time_sync <= 1'b1;
               @(posedge radio_clk);
               i_time_sync <= 1'b0;
               repeat (4) @(posedge radio_clk); // 2 sync stages plus the clear
            end
            default: begin
               @(posedge radio_clk);
               if (steps[n].chan == 2'd1) begin
                  i_db1_gpio_in    <= steps[n].data;
                  i_radio1_misc_in <= ~steps[n].data;
               end else begin
                  i_db0_gpio_in    <= steps[n].data;
                  i_radio0_misc_in <= ~steps[n].data;
               end
            end
         endcase
         $display("test %0d %s ch%0d addr %h: %s", n, op_name(steps[n].op),
                  steps[n].chan, steps[n].addr, (test_err == 0) ? "ok" : "mismatch");
      end
      $display("%0d tests, %0d checks, %0d errors", steps.size(), checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // budget of 20 cycles per table step
   initial begin
      wait (table_ready);
      repeat (steps.size() * 20 + 5) @(posedge radio_clk);
      $display("watchdog: run did not finish within %0d cycles", steps.size() * 20);
      $display("Simulation failed");
      $finish;
   end

endmodule

//--- files.f
+incdir+hw
hw/radio_types_pkg.sv
hw/fe_regs_pkg.sv
hw/fe_ctrl_if.sv
hw/fe_ctrl_router.sv
hw/db_fe_core.sv
hw/radio_board_map.sv
hw/radio_core_top.sv
bench/radio_core_asserts.sv
bench/radio_core_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f files.f --top-module radio_core_tb -o radio_core_sim
	./obj_dir/radio_core_sim | tee sim.log
	@if grep -q "Simulation failed" sim.log || ! grep -q "Simulation passed" sim.log; \
		then exit 1; fi

clean:
	rm -rf obj_dir sim.log
